/* verilog/rename_pkg.sv */
package rename_pkg;

    // ########################################
    // Sizes
    // ########################################

    parameter int NUM_LREGS        = 32;  // Architectural integer registers.
    parameter int DEF_RENAME_WIDTH = 2;
    parameter int DEF_COMMIT_WIDTH = 2;
    parameter int DEF_NUM_PREGS    = 48;  // Anything from 33 to 64.
    parameter int NUM_SRCS         = 2;

    typedef logic [4:0] lreg_idx_t;
    typedef logic [5:0] preg_idx_t;

    // ########################################
    // Instruction records
    // ########################################

    typedef enum logic [1:0] {
        UOP_ALU    = 2'd0,
        UOP_LOAD   = 2'd1,
        UOP_STORE  = 2'd2,
        UOP_BRANCH = 2'd3
    } uop_e;

    // One instruction as decode hands it over.
    typedef struct packed {
        uop_e                       uop;
        logic                       rd_wen;
        lreg_idx_t                  ilrd_idx;
        lreg_idx_t [NUM_SRCS-1:0]   ilrs_idx;
        logic [11:0]                imm;
    } dec_info_t;

    // Decode fields plus the physical registers picked by rename.
    typedef struct packed {
        uop_e                       uop;
        logic                       rd_wen;
        lreg_idx_t                  ilrd_idx;
        lreg_idx_t [NUM_SRCS-1:0]   ilrs_idx;
        logic [11:0]                imm;
        preg_idx_t                  iprd_idx;
        preg_idx_t                  prev_iprd_idx;
        preg_idx_t [NUM_SRCS-1:0]   iprs_idx;
    } rename_info_t;

    // What commit tells rename about a retired instruction.
    typedef struct packed {
        logic                       rd_wen;
        lreg_idx_t                  ilrd_idx;
        preg_idx_t                  iprd_idx;
        preg_idx_t                  prev_iprd_idx;
    } commit_info_t;

endpackage

/* verilog/free_list.sv */
`timescale 1ns/1ns

module free_list #(
    parameter int RENAME_WIDTH = rename_pkg::DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::DEF_COMMIT_WIDTH,
    parameter int NUM_PREGS    = rename_pkg::DEF_NUM_PREGS
) (
    input  logic                                        clk,
    input  logic                                        i_rst,
    input  logic [RENAME_WIDTH-1:0]                     i_alloc_req,
    input  logic                                        i_alloc_fire,
    input  logic [COMMIT_WIDTH-1:0]                     i_commit_vld,
    input  rename_pkg::commit_info_t [COMMIT_WIDTH-1:0] i_commit_info,
    input  logic                                        i_squash,
    output logic                                        o_can_alloc,
    output rename_pkg::preg_idx_t [RENAME_WIDTH-1:0]    o_alloc_pregs
);
    import rename_pkg::*;

    // Registers not held by the committed map.
    localparam int DEPTH = NUM_PREGS - NUM_LREGS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    preg_idx_t queue [DEPTH];
    ptr_t      spec_head;  // Next register to hand out.
    ptr_t      comm_head;  // Oldest register still owned by an in-flight instruction.
    ptr_t      tail;       // Where committed registers come back.
    cnt_t      free_cnt;   // Entries between spec_head and tail.

    int                      n_req;
    int                      n_push;
    logic [COMMIT_WIDTH-1:0] push_vld;
    ptr_t [COMMIT_WIDTH-1:0] push_ptr;

    function automatic ptr_t ptr_add(input ptr_t p, input int unsigned n);
        int unsigned sum;
        sum = p + n;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    // ########################################
    // Allocation side
    // ########################################

    // Requesting slots take consecutive entries in slot order.
    always_comb begin
        n_req = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_alloc_pregs[i] = '0;
            if (i_alloc_req[i]) begin
                o_alloc_pregs[i] = queue[ptr_add(spec_head, n_req)];
                n_req = n_req + 1;
            end
        end
    end

    assign o_can_alloc = (int'(free_cnt) >= n_req);

    // ########################################
    // Commit side
    // ########################################

    always_comb begin
        n_push = 0;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            push_vld[c] = i_commit_vld[c] & i_commit_info[c].rd_wen;
            push_ptr[c] = ptr_add(tail, n_push);
            if (push_vld[c]) begin
                n_push = n_push + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            spec_head <= '0;
            comm_head <= '0;
            tail      <= '0;
            free_cnt  <= cnt_t'(DEPTH);
        end else begin
            tail      <= ptr_add(tail, n_push);
            comm_head <= ptr_add(comm_head, n_push);
            if (i_squash) begin
                // Everything past the committed head is free again.
                spec_head <= ptr_add(comm_head, n_push);
                free_cnt  <= cnt_t'(DEPTH);
            end else if (i_alloc_fire) begin
                spec_head <= ptr_add(spec_head, n_req);
                free_cnt  <= cnt_t'(int'(free_cnt) + n_push - n_req);
            end else begin
                free_cnt  <= cnt_t'(int'(free_cnt) + n_push);
            end
        end
    end

    // The queue comes out of reset holding pregs 32 and up in order.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int e = 0; e < DEPTH; e++) begin
                queue[e] <= preg_idx_t'(NUM_LREGS + e);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (push_vld[c]) begin
                    queue[push_ptr[c]] <= i_commit_info[c].prev_iprd_idx;
                end
            end
        end
    end

endmodule

/* verilog/spec_map_table.sv */
`timescale 1ns/1ns

module spec_map_table #(
    parameter int RENAME_WIDTH = rename_pkg::DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::DEF_COMMIT_WIDTH
) (
    input  logic                                        clk,
    input  logic                                        i_rst,
    input  logic                                        i_fire,
    input  logic [RENAME_WIDTH-1:0]                     i_rd_wen,
    input  rename_pkg::lreg_idx_t [RENAME_WIDTH-1:0]    i_ilrd_idx,
    input  rename_pkg::lreg_idx_t [RENAME_WIDTH-1:0][rename_pkg::NUM_SRCS-1:0]
                                                        i_ilrs_idx,
    input  rename_pkg::preg_idx_t [RENAME_WIDTH-1:0]    i_new_pregs,
    input  logic [COMMIT_WIDTH-1:0]                     i_commit_vld,
    input  rename_pkg::commit_info_t [COMMIT_WIDTH-1:0] i_commit_info,
    input  logic                                        i_squash,
    output rename_pkg::preg_idx_t [RENAME_WIDTH-1:0][rename_pkg::NUM_SRCS-1:0]
                                                        o_iprs_idx,
    output rename_pkg::preg_idx_t [RENAME_WIDTH-1:0]    o_prev_iprd_idx,
    output rename_pkg::preg_idx_t [rename_pkg::NUM_LREGS-1:0]
                                                        o_spec_map
);
    import rename_pkg::*;

    preg_idx_t [NUM_LREGS-1:0] spec_map;
    preg_idx_t [NUM_LREGS-1:0] comm_map;
    preg_idx_t [NUM_LREGS-1:0] comm_map_nxt;

    // ########################################
    // Lookup with in-group bypass
    // ########################################

    // A later slot sees the new register of any earlier slot writing the same
    // architectural register. Scanning upward lets the nearest earlier slot win.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                o_iprs_idx[i][s] = spec_map[i_ilrs_idx[i][s]];
                for (int j = 0; j < i; j++) begin
                    if (i_rd_wen[j] && (i_ilrd_idx[j] == i_ilrs_idx[i][s])) begin
                        o_iprs_idx[i][s] = i_new_pregs[j];
                    end
                end
            end

            o_prev_iprd_idx[i] = spec_map[i_ilrd_idx[i]];
            for (int j = 0; j < i; j++) begin
                if (i_rd_wen[j] && (i_ilrd_idx[j] == i_ilrd_idx[i])) begin
                    o_prev_iprd_idx[i] = i_new_pregs[j];
                end
            end
        end
    end

    // ########################################
    // Committed map
    // ########################################

    // Commits apply in slot order. The x0 entry is never written.
    always_comb begin
        comm_map_nxt = comm_map;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c] && i_commit_info[c].rd_wen &&
                (i_commit_info[c].ilrd_idx != '0)) begin
                comm_map_nxt[i_commit_info[c].ilrd_idx] = i_commit_info[c].iprd_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                comm_map[l] <= preg_idx_t'(l);
            end
        end else begin
            comm_map <= comm_map_nxt;
        end
    end

    // ########################################
    // Speculative map
    // ########################################

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                spec_map[l] <= preg_idx_t'(l);  // Identity mapping.
            end
        end else if (i_squash) begin
            spec_map <= comm_map_nxt;  // Includes commits of the squash cycle.
        end else if (i_fire) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_rd_wen[i] && (i_ilrd_idx[i] != '0)) begin
                    spec_map[i_ilrd_idx[i]] <= i_new_pregs[i];  // Later slot wins.
                end
            end
        end
    end

    assign o_spec_map = spec_map;

endmodule

/* verilog/rename_stage.sv */
`timescale 1ns/1ns

module rename_stage #(
    parameter int RENAME_WIDTH = rename_pkg::DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::DEF_COMMIT_WIDTH,
    parameter int NUM_PREGS    = rename_pkg::DEF_NUM_PREGS
) (
    input  logic                                             clk,
    input  logic                                             i_rst,
    input  logic [RENAME_WIDTH-1:0]                          i_dec_vld,
    input  rename_pkg::dec_info_t [RENAME_WIDTH-1:0]         i_dec_info,
    input  logic                                             i_stall,
    input  logic                                             i_squash,
    input  logic [COMMIT_WIDTH-1:0]                          i_commit_vld,
    input  rename_pkg::commit_info_t [COMMIT_WIDTH-1:0]      i_commit_info,
    output logic                                             o_stall,
    output logic [RENAME_WIDTH-1:0]                          o_rename_vld,
    output rename_pkg::rename_info_t [RENAME_WIDTH-1:0]      o_rename_info,
    output rename_pkg::preg_idx_t [rename_pkg::NUM_LREGS-1:0] o_spec_map
);
    import rename_pkg::*;

    logic                                    can_alloc;
    logic                                    fire;
    logic [RENAME_WIDTH-1:0]                 alloc_req;
    preg_idx_t [RENAME_WIDTH-1:0]            alloc_pregs;
    preg_idx_t [RENAME_WIDTH-1:0]            prev_iprd_idx;
    lreg_idx_t [RENAME_WIDTH-1:0]            ilrd_idx;
    lreg_idx_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] ilrs_idx;
    preg_idx_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] iprs_idx;
    rename_info_t [RENAME_WIDTH-1:0]         rename_nxt;

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            alloc_req[i] = i_dec_vld[i] & i_dec_info[i].rd_wen;
            ilrd_idx[i]  = i_dec_info[i].ilrd_idx;
            ilrs_idx[i]  = i_dec_info[i].ilrs_idx;
        end
    end

    // Squash beats a fire in the same cycle.
    assign fire    = (|i_dec_vld) && can_alloc && !i_stall && !i_squash;
    assign o_stall = !can_alloc || i_stall;

    free_list #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .NUM_PREGS    (NUM_PREGS)
    ) u_free_list (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_alloc_req   (alloc_req),
        .i_alloc_fire  (fire),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_squash      (i_squash),
        .o_can_alloc   (can_alloc),
        .o_alloc_pregs (alloc_pregs)
    );

    spec_map_table #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_spec_map_table (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_fire          (fire),
        .i_rd_wen        (alloc_req),
        .i_ilrd_idx      (ilrd_idx),
        .i_ilrs_idx      (ilrs_idx),
        .i_new_pregs     (alloc_pregs),
        .i_commit_vld    (i_commit_vld),
        .i_commit_info   (i_commit_info),
        .i_squash        (i_squash),
        .o_iprs_idx      (iprs_idx),
        .o_prev_iprd_idx (prev_iprd_idx),
        .o_spec_map      (o_spec_map)
    );

    // ########################################
    // Output register toward dispatch
    // ########################################

    // Slots without a destination carry preg 0 in both rd fields.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rename_nxt[i].uop           = i_dec_info[i].uop;
            rename_nxt[i].rd_wen        = i_dec_info[i].rd_wen;
            rename_nxt[i].ilrd_idx      = i_dec_info[i].ilrd_idx;
            rename_nxt[i].ilrs_idx      = i_dec_info[i].ilrs_idx;
            rename_nxt[i].imm           = i_dec_info[i].imm;
            rename_nxt[i].iprd_idx      = alloc_req[i] ? alloc_pregs[i] : '0;
            rename_nxt[i].prev_iprd_idx = alloc_req[i] ? prev_iprd_idx[i] : '0;
            rename_nxt[i].iprs_idx      = iprs_idx[i];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_squash) begin
            o_rename_vld <= '0;
        end else if (!i_stall) begin
            o_rename_vld <= can_alloc ? i_dec_vld : '0;  // Empty group while short of pregs.
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_rename_info <= rename_nxt;
        end
    end

endmodule

/* verilog/rename_unit.sv */
`timescale 1ns/1ns

module rename_unit #(
    parameter int RENAME_WIDTH = rename_pkg::DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::DEF_COMMIT_WIDTH,
    parameter int NUM_PREGS    = rename_pkg::DEF_NUM_PREGS
) (
    input  logic                                             clk,
    input  logic                                             i_rst,
    // Decode.
    input  logic [RENAME_WIDTH-1:0]                          i_dec_vld,
    input  rename_pkg::dec_info_t [RENAME_WIDTH-1:0]         i_dec_info,
    output logic                                             o_stall,
    // Dispatch.
    input  logic                                             i_stall,
    output logic [RENAME_WIDTH-1:0]                          o_rename_vld,
    output rename_pkg::rename_info_t [RENAME_WIDTH-1:0]      o_rename_info,
    // Commit and recovery.
    input  logic                                             i_squash,
    input  logic [COMMIT_WIDTH-1:0]                          i_commit_vld,
    input  rename_pkg::commit_info_t [COMMIT_WIDTH-1:0]      i_commit_info,
    output rename_pkg::preg_idx_t [rename_pkg::NUM_LREGS-1:0] o_spec_map
);

    rename_stage #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .NUM_PREGS    (NUM_PREGS)
    ) u_rename_stage (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_dec_vld     (i_dec_vld),
        .i_dec_info    (i_dec_info),
        .i_stall       (i_stall),
        .i_squash      (i_squash),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .o_stall       (o_stall),
        .o_rename_vld  (o_rename_vld),
        .o_rename_info (o_rename_info),
        .o_spec_map    (o_spec_map)
    );

endmodule

/* verification/rename_unit_sva.sv */
`timescale 1ns/1ns

module rename_unit_sva #(
    parameter int RENAME_WIDTH = rename_pkg::DEF_RENAME_WIDTH,
    parameter int NUM_PREGS    = rename_pkg::DEF_NUM_PREGS
) (
    input logic                                     clk,
    input logic                                     i_rst,
    input logic                                     i_squash,
    input logic                                     fire,
    input logic [RENAME_WIDTH-1:0]                  alloc_req,
    input rename_pkg::preg_idx_t [RENAME_WIDTH-1:0] alloc_pregs,
    input logic [RENAME_WIDTH-1:0]                  o_rename_vld,
    input logic [7:0]                               free_cnt
);
    import rename_pkg::*;

    int fail_cnt = 0;  // Number of assertion failures so far.

    // The free list never holds more than the registers outside the committed map.
    a_free_bound: assert property (@(posedge clk) disable iff (i_rst)
        free_cnt <= 8'(NUM_PREGS - NUM_LREGS))
        else begin
            fail_cnt++;
            $error("free count above its bound");
        end

    a_squash_clear: assert property (@(posedge clk) disable iff (i_rst)
        i_squash |=> (o_rename_vld == '0))
        else begin
            fail_cnt++;
            $error("rename output valid after squash");
        end

    a_unique_alloc: assert property (@(posedge clk) disable iff (i_rst)
        (fire && alloc_req[0] && alloc_req[1]) |-> (alloc_pregs[0] != alloc_pregs[1]))
        else begin
            fail_cnt++;
            $error("both slots got the same physical register");
        end

endmodule

bind rename_stage rename_unit_sva #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .NUM_PREGS    (NUM_PREGS)
) u_rename_unit_sva (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_squash     (i_squash),
    .fire         (fire),
    .alloc_req    (alloc_req),
    .alloc_pregs  (alloc_pregs),
    .o_rename_vld (o_rename_vld),
    .free_cnt     (8'(u_free_list.free_cnt))
);

/* verification/tb_rename_unit.sv */
`timescale 1ns/1ns

module tb_rename_unit;
    import rename_pkg::*;

    localparam int DEPTH = DEF_NUM_PREGS - NUM_LREGS;

    typedef struct packed {
        int                       test;
        logic [1:0]               vld;
        logic [1:0]               wen;
        lreg_idx_t [1:0]          rd;
        lreg_idx_t [1:0][1:0]     rs;  // Slot, then source.
        logic                     stall;
        int                       ncommit;
        logic                     squash;
        logic                     exp_stall;
        logic                     rnd;
    } row_t;

    logic                                clk;
    logic                                i_rst;
    logic [1:0]                          i_dec_vld;
    dec_info_t [1:0]                     i_dec_info;
    logic                                i_stall;
    logic                                i_squash;
    logic [1:0]                          i_commit_vld;
    commit_info_t [1:0]                  i_commit_info;
    logic                                o_stall;
    logic [1:0]                          o_rename_vld;
    rename_info_t [1:0]                  o_rename_info;
    preg_idx_t [NUM_LREGS-1:0]           o_spec_map;

    // Reference model state.
    preg_idx_t          spec_map [NUM_LREGS];
    preg_idx_t          comm_map [NUM_LREGS];
    preg_idx_t          fq [DEPTH];
    int                 spec_head, comm_head, tail, free_cnt;
    commit_info_t       inflight [$];
    logic [1:0]         exp_vld;
    rename_info_t [1:0] exp_info;

    row_t        rows [$];
    string       names [1:6];
    int          errors, checks;
    logic [31:0] lfsr;

    rename_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input int test, input logic [1:0] vld, input logic [1:0] wen,
                           input lreg_idx_t rd0, input lreg_idx_t a0, input lreg_idx_t b0,
                           input lreg_idx_t rd1, input lreg_idx_t a1, input lreg_idx_t b1,
                           input logic stall, input int ncommit, input logic squash,
                           input logic exp_stall);
        row_t r;
        r = '0;
        r.test = test;
        r.vld = vld;
        r.wen = wen;
        r.rd[0] = rd0;
        r.rd[1] = rd1;
        r.rs[0] = {b0, a0};
        r.rs[1] = {b1, a1};
        r.stall = stall;
        r.ncommit = ncommit;
        r.squash = squash;
        r.exp_stall = exp_stall;
        rows.push_back(r);
    endtask

    task automatic add_random_row(input int test);
        row_t r;
        r = '0;
        r.test = test;
        r.rnd = 1'b1;
        r.vld = 2'(rand_bits(2));
        for (int i = 0; i < 2; i++) begin
            r.wen[i] = 1'(rand_bits(1));
            r.rd[i] = lreg_idx_t'(rand_bits(5));
            if (r.rd[i] == '0) r.wen[i] = 1'b0;  // Decode never writes x0.
            r.rs[i][0] = lreg_idx_t'(rand_bits(5));
            r.rs[i][1] = lreg_idx_t'(rand_bits(5));
        end
        r.stall = (rand_bits(2) == 0);
        r.ncommit = rand_bits(2);
        r.squash = (rand_bits(5) == 0);
        rows.push_back(r);
    endtask

    task automatic check_outputs();
        for (int i = 0; i < 2; i++) begin
            check_value($sformatf("o_rename_vld[%0d]", i), o_rename_vld[i], exp_vld[i]);
            if (exp_vld[i]) begin
                check_value($sformatf("o_rename_info[%0d]", i), o_rename_info[i], exp_info[i]);
            end
        end
        for (int l = 0; l < NUM_LREGS; l++) begin
            check_value($sformatf("o_spec_map[%0d]", l), o_spec_map[l], spec_map[l]);
        end
    endtask

    // ########################################
    // Reference rename model
    // ########################################

    task automatic model_step(input row_t r, input dec_info_t [1:0] dec,
                              input logic [1:0] cvld, input commit_info_t [1:0] cinfo);
        logic [1:0]         req;
        preg_idx_t [1:0]    pregs;
        rename_info_t [1:0] nxt;
        commit_info_t       ci;
        int                 n_req, n_push;
        logic               can, fire;
        n_req = 0;
        for (int i = 0; i < 2; i++) begin
            req[i] = r.vld[i] & r.wen[i];
            pregs[i] = '0;
            if (req[i]) begin
                pregs[i] = fq[(spec_head + n_req) % DEPTH];
                n_req++;
            end
        end
        can = (free_cnt >= n_req);
        check_value("o_stall", o_stall, !can || r.stall);
        if (!r.rnd) check_value("o_stall", o_stall, r.exp_stall);
        fire = (|r.vld) && can && !r.stall && !r.squash;
        for (int i = 0; i < 2; i++) begin
            nxt[i] = '0;
            nxt[i].uop = dec[i].uop;
            nxt[i].rd_wen = dec[i].rd_wen;
            nxt[i].ilrd_idx = dec[i].ilrd_idx;
            nxt[i].ilrs_idx = dec[i].ilrs_idx;
            nxt[i].imm = dec[i].imm;
            nxt[i].iprd_idx = pregs[i];
            for (int s = 0; s < 2; s++) begin
                nxt[i].iprs_idx[s] = spec_map[r.rs[i][s]];
                if (i == 1 && req[0] && r.rd[0] == r.rs[1][s]) nxt[i].iprs_idx[s] = pregs[0];
            end
            if (req[i]) begin
                nxt[i].prev_iprd_idx = spec_map[r.rd[i]];
                if (i == 1 && req[0] && r.rd[0] == r.rd[1]) nxt[i].prev_iprd_idx = pregs[0];
            end
        end
        if (r.squash) exp_vld = '0;
        else if (!r.stall) exp_vld = can ? r.vld : 2'b00;
        if (!r.stall) exp_info = nxt;

        // Commit frees the previous register and then squash or fire applies.
        n_push = 0;
        for (int c = 0; c < 2; c++) begin
            if (cvld[c] && cinfo[c].rd_wen) begin
                comm_map[cinfo[c].ilrd_idx] = cinfo[c].iprd_idx;
                fq[tail] = cinfo[c].prev_iprd_idx;
                tail = (tail + 1) % DEPTH;
                comm_head = (comm_head + 1) % DEPTH;
                n_push++;
            end
        end
        if (r.squash) begin
            spec_map = comm_map;
            spec_head = comm_head;
            free_cnt = DEPTH;
            inflight.delete();
        end else if (fire) begin
            for (int i = 0; i < 2; i++) begin
                if (req[i]) begin
                    spec_map[r.rd[i]] = pregs[i];
                    ci.rd_wen = 1'b1;
                    ci.ilrd_idx = r.rd[i];
                    ci.iprd_idx = pregs[i];
                    ci.prev_iprd_idx = nxt[i].prev_iprd_idx;
                    inflight.push_back(ci);
                end
            end
            spec_head = (spec_head + n_req) % DEPTH;
            free_cnt = free_cnt + n_push - n_req;
        end else begin
            free_cnt = free_cnt + n_push;
        end
    endtask

    task automatic report_test(input int t, input int n);
        $display("Test %0d %s: %0d errors", t, names[t], n);
    endtask

    initial begin
        row_t               r;
        dec_info_t [1:0]    dec;
        commit_info_t [1:0] cinfo;
        logic [1:0]         cvld;
        int                 ncm, cur_test, test_base, guard;
        i_rst = 1'b1;
        i_dec_vld = '0;
        i_dec_info = '0;
        i_stall = 1'b0;
        i_squash = 1'b0;
        i_commit_vld = '0;
        i_commit_info = '0;
        errors = 0;
        checks = 0;
        lfsr = 32'h64b79aef;
        for (int l = 0; l < NUM_LREGS; l++) begin
            spec_map[l] = preg_idx_t'(l);
            comm_map[l] = preg_idx_t'(l);
        end
        for (int e = 0; e < DEPTH; e++) fq[e] = preg_idx_t'(NUM_LREGS + e);
        spec_head = 0;
        comm_head = 0;
        tail = 0;
        free_cnt = DEPTH;
        exp_vld = '0;
        exp_info = '0;
        names[1] = "reset mapping";
        names[2] = "group bypass";
        names[3] = "exhaust and stall";
        names[4] = "commit and wrap";
        names[5] = "squash";
        names[6] = "random";

        // ########################################
        // Stimulus table
        // ########################################
        add_row(1, 2'b11, 2'b11, 5, 1, 2, 6, 3, 4, 0, 0, 0, 0);
        add_row(2, 2'b11, 2'b11, 7, 1, 1, 7, 7, 5, 0, 0, 0, 0);
        add_row(2, 2'b11, 2'b01, 8, 7, 0, 0, 8, 7, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 9, 1, 2, 10, 9, 3, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 11, 4, 5, 12, 6, 7, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 13, 8, 9, 14, 13, 1, 1, 0, 0, 1);
        add_row(3, 2'b11, 2'b11, 13, 8, 9, 14, 13, 1, 1, 0, 0, 1);
        add_row(3, 2'b11, 2'b11, 13, 8, 9, 14, 13, 1, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 15, 2, 3, 16, 15, 4, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 17, 5, 6, 18, 17, 7, 0, 0, 0, 0);
        add_row(3, 2'b11, 2'b11, 19, 9, 10, 20, 19, 11, 0, 0, 0, 1);
        add_row(3, 2'b11, 2'b11, 19, 9, 10, 20, 19, 11, 0, 0, 0, 1);
        add_row(4, 2'b11, 2'b11, 19, 9, 10, 20, 19, 11, 0, 2, 0, 1);
        add_row(4, 2'b11, 2'b11, 19, 9, 10, 20, 19, 11, 0, 2, 0, 0);
        add_row(4, 2'b11, 2'b11, 21, 5, 6, 22, 21, 7, 0, 2, 0, 0);
        add_row(5, 2'b11, 2'b11, 25, 1, 2, 26, 3, 4, 0, 1, 1, 0);
        add_row(5, 2'b11, 2'b11, 23, 5, 6, 24, 7, 8, 0, 0, 0, 0);
        add_row(5, 2'b00, 2'b00, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 40; k++) add_random_row(6);

        repeat (3) @(posedge clk);
        i_rst <= 1'b0;
        guard = 0;
        @(negedge clk);
        while (o_stall !== 1'b0) begin
            guard++;
            if (guard > 20) begin
                $display("Timed out waiting for o_stall to fall after reset");
                $display("Checks failed");
                $finish;
            end
            @(negedge clk);
        end

        cur_test = rows[0].test;
        test_base = 0;
        foreach (rows[k]) begin
            r = rows[k];
            cvld = '0;
            cinfo = '0;
            ncm = (r.ncommit < inflight.size()) ? r.ncommit : inflight.size();
            if (ncm > 2) ncm = 2;
            for (int c = 0; c < ncm; c++) begin
                cvld[c] = 1'b1;
                cinfo[c] = inflight.pop_front();
            end
            for (int i = 0; i < 2; i++) begin
                dec[i].uop = uop_e'(k % 4);
                dec[i].rd_wen = r.wen[i];
                dec[i].ilrd_idx = r.rd[i];
                dec[i].ilrs_idx = r.rs[i];
                dec[i].imm = 12'(k * 2 + i);
            end
            @(posedge clk);
            i_dec_vld <= r.vld;
            i_dec_info <= dec;
            i_stall <= r.stall;
            i_squash <= r.squash;
            i_commit_vld <= cvld;
            i_commit_info <= cinfo;
            @(negedge clk);
            check_outputs();
            if (r.test != cur_test) begin
                report_test(cur_test, errors - test_base);
                cur_test = r.test;
                test_base = errors;
            end
            model_step(r, dec, cvld, cinfo);
        end
        @(posedge clk);
        i_dec_vld <= '0;
        i_stall <= 1'b0;
        i_squash <= 1'b0;
        i_commit_vld <= '0;
        @(negedge clk);
        check_outputs();
        report_test(cur_test, errors - test_base);

        errors = errors + uut.u_rename_stage.u_rename_unit_sva.fail_cnt;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/spec_map_table.sv
verilog/rename_stage.sv
verilog/rename_unit.sv
verification/rename_unit_sva.sv
verification/tb_rename_unit.sv
